//--- list.f
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/fwd_if.sv
design/reg_file.sv
design/front_end.sv
design/execute_unit.sv
design/mem_stage.sv
design/writeback_stage.sv
design/rv_core.sv
bench/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, then search the log for the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_rv_core -o sim_rv_core > build.log 2>&1 \
  && ./obj_dir/sim_rv_core > sim.log 2>&1
grep -q "=== PASS ===" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- bench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  import pipe_pkg::*;

  logic          clk;
  logic          rst;
  logic [31:0]   pc_to_imem;
  logic [31:0]   addr_to_dmem;
  logic [31:0]   store_data_to_dmem;
  logic [3:0]    store_we_to_dmem;
  logic          halt;
  logic [31:0]   trace_pc;
  logic [31:0]   trace_insn;
  cycle_status_e trace_status;

  // shared instruction and data memory of 4 KiB
  logic [31:0] mem [0:1023];
  logic [31:0] rng_state;
  logic [31:0] gold [0:31];
  int          pc_w;
  logic [31:0] exp_pc [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] store_log [$];
  int          l2u_store;
  logic [31:0] l2u_imm;
  int          taken_count;
  int          l2u_count;
  bit          seen_first;
  bit          done;
  int          cycles;

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) dut_i (
    .clk                          (clk),
    .rst                          (rst),
    .pc_to_imem                   (pc_to_imem),
    .insn_from_imem               (mem[pc_to_imem[11:2]]),
    .addr_to_dmem                 (addr_to_dmem),
    .load_data_from_dmem          (mem[addr_to_dmem[11:2]]),
    .store_data_to_dmem           (store_data_to_dmem),
    .store_we_to_dmem             (store_we_to_dmem),
    .halt                         (halt),
    .trace_writeback_pc           (trace_pc),
    .trace_writeback_insn         (trace_insn),
    .trace_writeback_cycle_status (trace_status)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (store_we_to_dmem != 4'b0000) begin
      mem[addr_to_dmem[11:2]] <= store_data_to_dmem;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  function automatic logic [31:0] enc_i(logic [31:0] imm, logic [31:0] rs1, logic [31:0] f3,
                                        logic [31:0] rd, logic [31:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_r(logic [31:0] f7, logic [31:0] rs2, logic [31:0] rs1,
                                        logic [31:0] f3, logic [31:0] rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] enc_s(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1,
                                        logic [31:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, logic [31:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] sext12(logic [31:0] v);
    return {{20{v[11]}}, v[11:0]};
  endfunction

  // reference RV32I alu where alt selects sub and sra
  function automatic logic [31:0] ref_alu(logic [31:0] f3, bit alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3[2:0])
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_value(input bit ok, input string what);
    assert (ok) else begin
      $display("Mismatch at %0t ns: %s", $time, what);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_event(input bit ok, input string what);
    assert (ok) else begin
      $display("Error at %0t ns: %s", $time, what);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic emit(input logic [31:0] insn, input bit executed);
    mem[pc_w] <= insn;
    if (executed) begin
      exp_pc.push_back(32'(pc_w * 4));
    end
    pc_w++;
  endtask

  task automatic set_reg(input int rd, input logic [31:0] value);
    if (rd != 0) begin
      gold[rd] = value;
    end
  endtask

  task automatic store_word(input int rs2, input int offset, input bit executed);
    emit(enc_s(32'(offset), 32'(rs2), 32'd10), executed);
    if (executed) begin
      exp_addr.push_back(gold[10] + 32'(offset));
      exp_data.push_back(gold[rs2]);
    end
  endtask

  task automatic load_const(input int rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value - sext12(value);
    emit({upper[31:12], 5'(rd), 7'h37}, 1'b1);
    emit(enc_i(value, 32'(rd), 32'd0, 32'(rd), 32'h13), 1'b1);
    set_reg(rd, value);
  endtask

  task automatic build_program();
    logic [31:0] f3;
    logic [31:0] imm;
    bit          alt;
    int          rd;
    int          rd2;
    logic [31:0] p;
    for (int i = 0; i < 1024; i++) begin
      mem[i] <= 32'h0;
    end
    for (int i = 0; i < 32; i++) begin
      gold[i] = 32'h0;
    end
    pc_w = 0;
    emit(enc_i(32'h400, 32'd0, 32'd0, 32'd10, 32'h13), 1'b1);
    set_reg(10, 32'h400);
    // dependent alu chains with each result stored
    for (int k = 0; k < 6; k++) begin
      load_const(1, next_rand());
      load_const(2, next_rand());
      f3 = next_rand() % 8;
      alt = (f3 == 0 || f3 == 5) && next_rand() % 2 == 1;
      rd = 3 + int'(next_rand() % 7);
      emit(enc_r(alt ? 32'h20 : 32'h0, 32'd2, 32'd1, f3, 32'(rd)), 1'b1);
      set_reg(rd, ref_alu(f3, alt, gold[1], gold[2]));
      f3 = next_rand() % 8;
      imm = next_rand() & 32'hfff;
      alt = f3 == 5 && next_rand() % 2 == 1;
      if (f3 == 1 || f3 == 5) begin
        imm = (alt ? 32'h400 : 32'h0) | (imm & 32'h1f);
      end
      rd2 = 3 + int'(next_rand() % 7);
      emit(enc_i(imm, 32'(rd), f3, 32'(rd2), 32'h13), 1'b1);
      set_reg(rd2, ref_alu(f3, alt, gold[rd], sext12(imm)));
      store_word(rd2, 8 * k, 1'b1);
      store_word(rd, 8 * k + 4, 1'b1);
    end
    // x0 must stay zero
    emit(enc_r(32'h0, 32'd2, 32'd1, 32'd0, 32'd0), 1'b1);
    store_word(0, 32'h60, 1'b1);
    // store, load and a dependent add
    l2u_store = exp_addr.size();
    store_word(1, 32'h70, 1'b1);
    emit(enc_i(32'h70, 32'd10, 32'd2, 32'd5, 32'h03), 1'b1);
    set_reg(5, gold[1]);
    imm = next_rand() & 32'hfff;
    l2u_imm = imm;
    emit(enc_i(imm, 32'd5, 32'd0, 32'd6, 32'h13), 1'b1);
    set_reg(6, gold[5] + sext12(imm));
    store_word(6, 32'h74, 1'b1);
    // control flow
    emit(enc_i(32'd5, 32'd0, 32'd0, 32'd1, 32'h13), 1'b1);
    emit(enc_i(32'd5, 32'd0, 32'd0, 32'd2, 32'h13), 1'b1);
    set_reg(1, 32'd5);
    set_reg(2, 32'd5);
    emit(enc_b(32'd8, 32'd2, 32'd1, 32'd0), 1'b1);
    store_word(1, 32'h90, 1'b0);
    emit(enc_b(32'd8, 32'd2, 32'd1, 32'd1), 1'b1);
    emit(enc_i(32'd3, 32'd0, 32'd0, 32'd7, 32'h13), 1'b1);
    set_reg(7, 32'd3);
    set_reg(11, 32'(pc_w * 4 + 4));
    emit(enc_j(32'd8, 32'd11), 1'b1);
    store_word(1, 32'h90, 1'b0);
    store_word(11, 32'h80, 1'b1);
    p = 32'(pc_w * 4);
    emit({20'h0, 5'd12, 7'h17}, 1'b1);
    set_reg(12, p);
    // odd offset, the target drops bit 0
    emit(enc_i(32'd17, 32'd12, 32'd0, 32'd13, 32'h67), 1'b1);
    set_reg(13, p + 32'd8);
    store_word(1, 32'h90, 1'b0);
    store_word(2, 32'h90, 1'b0);
    store_word(13, 32'h84, 1'b1);
    store_word(7, 32'h88, 1'b1);
    emit(32'h0000_0073, 1'b1);
  endtask

  task automatic watch_cycle();
    logic [31:0] pc;
    if (store_we_to_dmem != 4'b0000) begin
      check_event(exp_addr.size() > 0, "store seen with none expected");
      check_value(store_we_to_dmem == 4'b1111, "store strobe not all ones");
      check_value(addr_to_dmem == exp_addr[0], $sformatf("store address %h, expected %h",
                  addr_to_dmem, exp_addr[0]));
      check_value(store_data_to_dmem == exp_data[0], $sformatf("store data %h, expected %h",
                  store_data_to_dmem, exp_data[0]));
      store_log.push_back(store_data_to_dmem);
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
    end
    if (trace_status == CYCLE_NO_STALL) begin
      seen_first = 1'b1;
      check_event(exp_pc.size() > 0, "instruction retired past the program end");
      pc = exp_pc.pop_front();
      check_value(trace_pc == pc, $sformatf("trace pc %h, expected %h", trace_pc, pc));
      check_value(trace_insn == mem[pc[11:2]], "trace instruction differs from memory");
    end else begin
      check_value(seen_first || trace_status == CYCLE_RESET, "bubble before first retire");
      check_value(halt == 1'b0, "halt raised by a bubble");
    end
    if (trace_status == CYCLE_TAKEN_BRANCH) begin
      taken_count++;
    end
    if (trace_status == CYCLE_LOAD2USE) begin
      l2u_count++;
    end
    if (halt) begin
      check_value(trace_insn == 32'h0000_0073, "halt without ecall in writeback");
      done = 1'b1;
    end
  endtask

  initial begin
    rst = 1'b1;
    rng_state = 32'h1be2;
    taken_count = 0;
    l2u_count = 0;
    seen_first = 1'b0;
    done = 1'b0;
    cycles = 0;
    build_program();
    @(posedge clk);
    @(negedge clk);
    check_value(halt == 1'b0 && store_we_to_dmem == 4'b0000, "outputs active in reset");
    check_value(trace_status == CYCLE_RESET, "trace status not reset during reset");
    @(posedge clk);
    #1 rst = 1'b0;
    while (!done && cycles < 2000) begin
      @(negedge clk);
      cycles++;
      watch_cycle();
    end
    if (!done) begin
      $display("Timeout: halt did not rise within 2000 cycles");
      $display("=== FAIL ===");
      $fatal(1);
    end else begin
      for (int i = 0; i < 4; i++) begin
        @(negedge clk);
        check_event(store_we_to_dmem == 4'b0000, "store seen after halt");
      end
      check_value(exp_pc.size() == 0, "instructions missing from the trace");
      check_value(exp_addr.size() == 0, "expected stores did not happen");
      check_value(store_log[l2u_store + 1] == store_log[l2u_store] + sext12(l2u_imm),
                  $sformatf("load-use result %h, loaded word %h",
                  store_log[l2u_store + 1], store_log[l2u_store]));
      check_value(taken_count == 6, $sformatf("%0d taken-branch bubbles, expected 6",
                  taken_count));
      check_value(l2u_count == 1, $sformatf("%0d load-use bubbles, expected 1", l2u_count));
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input wire clk,
  input wire rst,
  output rv_isa_pkg::word_t pc_to_imem,
  input wire rv_isa_pkg::insn_t insn_from_imem,
  output rv_isa_pkg::word_t addr_to_dmem,
  input wire rv_isa_pkg::word_t load_data_from_dmem,
  output rv_isa_pkg::word_t store_data_to_dmem,
  output logic [3:0] store_we_to_dmem,
  output logic halt,
  output rv_isa_pkg::word_t trace_writeback_pc,
  output rv_isa_pkg::insn_t trace_writeback_insn,
  output pipe_pkg::cycle_status_e trace_writeback_cycle_status
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  x_stage_t x_state;
  m_stage_t m_state;
  w_stage_t w_state;
  logic     redirect;
  word_t    redirect_pc;
  reg_idx_t ex_rd;
  logic     ex_is_load;

  // bypass and register write results from memory and writeback
  fwd_if fwd ();

  front_end #(
    .RESET_PC (RESET_PC)
  ) front_end_i (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .ex_rd          (ex_rd),
    .ex_is_load     (ex_is_load),
    .fwd            (fwd.sink),
    .x_state        (x_state)
  );

  execute_unit execute_unit_i (
    .clk         (clk),
    .rst         (rst),
    .x_state     (x_state),
    .fwd         (fwd.sink),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_rd       (ex_rd),
    .ex_is_load  (ex_is_load),
    .m_state     (m_state)
  );

  mem_stage mem_stage_i (
    .clk                 (clk),
    .rst                 (rst),
    .m_state             (m_state),
    .addr_to_dmem        (addr_to_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .load_data_from_dmem (load_data_from_dmem),
    .fwd                 (fwd.mem_src),
    .w_state             (w_state)
  );

  writeback_stage writeback_stage_i (
    .w_state                      (w_state),
    .fwd                          (fwd.wb_src),
    .halt                         (halt),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status)
  );

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
  input wire pipe_pkg::w_stage_t w_state,
  fwd_if.wb_src fwd,
  output logic halt,
  output rv_isa_pkg::word_t trace_writeback_pc,
  output rv_isa_pkg::insn_t trace_writeback_insn,
  output pipe_pkg::cycle_status_e trace_writeback_cycle_status
);

  import rv_isa_pkg::*;

  opcode_t opcode;

  assign opcode = w_state.insn[6:0];

  // nonzero w_rd is the register file write enable
  assign fwd.w_rd = writes_rd(opcode) ? w_state.insn[11:7] : '0;
  assign fwd.w_value = (opcode == OP_LOAD) ? w_state.load_data : w_state.alu_result;

  // ecall has every bit above the opcode clear
  assign halt = (opcode == OP_SYSTEM) && (w_state.insn[31:7] == '0);

  assign trace_writeback_pc = w_state.pc;
  assign trace_writeback_insn = w_state.insn;
  assign trace_writeback_cycle_status = w_state.status;

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
  input wire clk,
  input wire rst,
  input wire pipe_pkg::m_stage_t m_state,
  output rv_isa_pkg::word_t addr_to_dmem,
  output rv_isa_pkg::word_t store_data_to_dmem,
  output logic [3:0] store_we_to_dmem,
  input wire rv_isa_pkg::word_t load_data_from_dmem,
  fwd_if.mem_src fwd,
  output pipe_pkg::w_stage_t w_state
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  opcode_t opcode;
  logic    is_load;
  logic    is_store;

  assign opcode = m_state.insn[6:0];
  assign is_load = opcode == OP_LOAD;
  assign is_store = opcode == OP_STORE;

  // only word accesses, so a store writes all four bytes
  assign addr_to_dmem = (is_load || is_store) ? m_state.alu_result : '0;
  assign store_data_to_dmem = is_store ? m_state.store_data : '0;
  assign store_we_to_dmem = is_store ? 4'b1111 : 4'b0000;

  // a load in this stage never feeds execute, the load-use bubble sees to that
  assign fwd.m_rd = writes_rd(opcode) ? m_state.insn[11:7] : '0;
  assign fwd.m_value = m_state.alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_state <= '{pc: '0, insn: NOP_INSN, status: CYCLE_RESET,
                   alu_result: '0, load_data: '0};
    end else begin
      w_state <= '{pc: m_state.pc, insn: m_state.insn, status: m_state.status,
                   alu_result: m_state.alu_result,
                   load_data: is_load ? load_data_from_dmem : '0};
    end
  end

endmodule

`default_nettype wire

//--- design/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input wire clk,
  input wire rst,
  input wire pipe_pkg::x_stage_t x_state,
  fwd_if.sink fwd,
  output logic redirect,
  output rv_isa_pkg::word_t redirect_pc,
  output rv_isa_pkg::reg_idx_t ex_rd,
  output logic ex_is_load,
  output pipe_pkg::m_stage_t m_state
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  insn_t      insn;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  word_t      rs1_v;
  word_t      rs2_v;
  word_t      link;
  word_t      result;

  // the newer memory stage result wins over writeback
  function automatic word_t pick_operand(reg_idx_t src, word_t held, reg_idx_t m_rd,
                                         word_t m_value, reg_idx_t w_rd, word_t w_value);
    if (m_rd != '0 && m_rd == src) begin
      return m_value;
    end
    if (w_rd != '0 && w_rd == src) begin
      return w_value;
    end
    return held;
  endfunction

  // sub only applies to the register form, arith selects sra over srl
  function automatic word_t alu_op(logic [2:0] f3, logic sub, logic arith, word_t a, word_t b);
    case (f3)
      F3_ADD: begin
        if (sub) begin
          return a - b;
        end
        return a + b;
      end
      F3_SLL: return a << b[4:0];
      F3_SLT: return {31'b0, $signed(a) < $signed(b)};
      F3_SLTU: return {31'b0, a < b};
      F3_XOR: return a ^ b;
      F3_SR: begin
        if (arith) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      F3_OR: return a | b;
      default: return a & b;
    endcase
  endfunction

  assign insn = x_state.insn;
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign alt = insn[31:25] == ALT_FUNCT7;
  assign rs1 = insn[19:15];
  assign rs2 = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign rs1_v = pick_operand(rs1, x_state.rs1_value, fwd.m_rd, fwd.m_value,
                              fwd.w_rd, fwd.w_value);
  assign rs2_v = pick_operand(rs2, x_state.rs2_value, fwd.m_rd, fwd.m_value,
                              fwd.w_rd, fwd.w_value);

  assign link = x_state.pc + 32'd4;

  always_comb begin
    result = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    case (opcode)
      OP_LUI: result = imm_u;
      OP_AUIPC: result = x_state.pc + imm_u;
      OP_REG_IMM: result = alu_op(funct3, 1'b0, alt, rs1_v, imm_i);
      OP_REG_REG: result = alu_op(funct3, alt, alt, rs1_v, rs2_v);
      // address computed here, memory stage uses it directly
      OP_LOAD: result = rs1_v + imm_i;
      OP_STORE: result = rs1_v + imm_s;
      OP_JAL: begin
        result = link;
        redirect = 1'b1;
        redirect_pc = x_state.pc + imm_j;
      end
      OP_JALR: begin
        result = link;
        redirect = 1'b1;
        redirect_pc = (rs1_v + imm_i) & ~32'h1;
      end
      OP_BRANCH: begin
        redirect_pc = x_state.pc + imm_b;
        case (funct3)
          F3_BEQ: redirect = rs1_v == rs2_v;
          F3_BNE: redirect = rs1_v != rs2_v;
          F3_BLT: redirect = $signed(rs1_v) < $signed(rs2_v);
          F3_BGE: redirect = $signed(rs1_v) >= $signed(rs2_v);
          F3_BLTU: redirect = rs1_v < rs2_v;
          F3_BGEU: redirect = rs1_v >= rs2_v;
          default: redirect = 1'b0;
        endcase
      end
      default: result = '0;
    endcase
  end

  // load-use check in the front end
  assign ex_rd = insn[11:7];
  assign ex_is_load = opcode == OP_LOAD;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_state <= '{pc: '0, insn: NOP_INSN, status: CYCLE_RESET,
                   alu_result: '0, store_data: '0};
    end else begin
      m_state <= '{pc: x_state.pc, insn: insn, status: x_state.status,
                   alu_result: result, store_data: rs2_v};
    end
  end

endmodule

`default_nettype wire

//--- design/front_end.sv
`timescale 1ns/1ns
`default_nettype none

module front_end #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input wire clk,
  input wire rst,
  output rv_isa_pkg::word_t pc_to_imem,
  input wire rv_isa_pkg::insn_t insn_from_imem,
  input wire redirect,
  input wire rv_isa_pkg::word_t redirect_pc,
  input wire rv_isa_pkg::reg_idx_t ex_rd,
  input wire ex_is_load,
  fwd_if.sink fwd,
  output pipe_pkg::x_stage_t x_state
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  word_t         pc;
  word_t         d_pc;
  insn_t         d_insn;
  cycle_status_e d_status;
  opcode_t       d_opcode;
  reg_idx_t      d_rs1;
  reg_idx_t      d_rs2;
  logic          uses_rs1;
  logic          uses_rs2;
  logic          stall;
  word_t         rf_rs1_value;
  word_t         rf_rs2_value;
  word_t         rs1_value;
  word_t         rs2_value;

  assign pc_to_imem = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // decode register, holds its instruction while the load-use bubble goes out
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc <= '0;
      d_insn <= NOP_INSN;
      d_status <= CYCLE_RESET;
    end else if (redirect) begin
      // fetched on the wrong path
      d_pc <= '0;
      d_insn <= NOP_INSN;
      d_status <= CYCLE_TAKEN_BRANCH;
    end else if (!stall) begin
      d_pc <= pc;
      d_insn <= insn_from_imem;
      d_status <= CYCLE_NO_STALL;
    end
  end

  assign d_opcode = d_insn[6:0];
  assign d_rs1 = d_insn[19:15];
  assign d_rs2 = d_insn[24:20];

  // which source fields the decoded instruction really reads
  assign uses_rs1 = d_opcode inside {OP_REG_REG, OP_REG_IMM, OP_LOAD, OP_STORE, OP_BRANCH,
                                     OP_JALR};
  assign uses_rs2 = d_opcode inside {OP_REG_REG, OP_STORE, OP_BRANCH};

  // load data only exists after memory, one bubble lets it reach writeback
  assign stall = ex_is_load && (ex_rd != '0) &&
                 ((uses_rs1 && (d_rs1 == ex_rd)) || (uses_rs2 && (d_rs2 == ex_rd)));

  reg_file rf_i (
    .clk       (clk),
    .rst       (rst),
    .rs1       (d_rs1),
    .rs2       (d_rs2),
    .rs1_value (rf_rs1_value),
    .rs2_value (rf_rs2_value),
    .wr        (fwd)
  );

  // the register file write lands at the edge, so bypass it here
  assign rs1_value = (fwd.w_rd != '0 && fwd.w_rd == d_rs1) ? fwd.w_value : rf_rs1_value;
  assign rs2_value = (fwd.w_rd != '0 && fwd.w_rd == d_rs2) ? fwd.w_value : rf_rs2_value;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_state <= '{pc: '0, insn: NOP_INSN, status: CYCLE_RESET,
                   rs1_value: '0, rs2_value: '0};
    end else if (redirect) begin
      x_state <= '{pc: '0, insn: NOP_INSN, status: CYCLE_TAKEN_BRANCH,
                   rs1_value: '0, rs2_value: '0};
    end else if (stall) begin
      x_state <= '{pc: '0, insn: NOP_INSN, status: CYCLE_LOAD2USE,
                   rs1_value: '0, rs2_value: '0};
    end else begin
      x_state <= '{pc: d_pc, insn: d_insn, status: d_status,
                   rs1_value: rs1_value, rs2_value: rs2_value};
    end
  end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input wire clk,
  input wire rst,
  input wire rv_isa_pkg::reg_idx_t rs1,
  input wire rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t rs1_value,
  output rv_isa_pkg::word_t rs2_value,
  fwd_if.sink wr
);

  import rv_isa_pkg::*;

  localparam int NUM_REGS = 32;

  word_t regs [NUM_REGS];

  assign rs1_value = regs[rs1];
  assign rs2_value = regs[rs2];

  // x0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.w_rd != '0) begin
      regs[wr.w_rd] <= wr.w_value;
    end
  end

endmodule

`default_nettype wire

//--- design/fwd_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fwd_if;

  import rv_isa_pkg::*;

  // memory stage result, m_rd is zero when nothing gets written
  reg_idx_t m_rd;
  word_t    m_value;

  // writeback result, also the register file write port
  reg_idx_t w_rd;
  word_t    w_value;

  modport mem_src (output m_rd, output m_value);
  modport wb_src (output w_rd, output w_value);
  modport sink (input m_rd, input m_value, input w_rd, input w_value);

endinterface

`default_nettype wire

//--- design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  import rv_isa_pkg::*;

  // what the instruction in a stage is, or why it is a bubble
  typedef enum logic [1:0] {
    CYCLE_NO_STALL     = 2'd0,
    CYCLE_RESET        = 2'd1,
    CYCLE_TAKEN_BRANCH = 2'd2,
    CYCLE_LOAD2USE     = 2'd3
  } cycle_status_e;

  // state at the start of execute
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    word_t         rs1_value;
    word_t         rs2_value;
  } x_stage_t;

  // state at the start of memory
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    word_t         alu_result;
    word_t         store_data;
  } m_stage_t;

  // state at the start of writeback
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    word_t         alu_result;
    word_t         load_data;
  } w_stage_t;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // base opcodes, see the RV32I opcode map
  localparam opcode_t OP_LOAD    = 7'b00_000_11;
  localparam opcode_t OP_STORE   = 7'b01_000_11;
  localparam opcode_t OP_BRANCH  = 7'b11_000_11;
  localparam opcode_t OP_JALR    = 7'b11_001_11;
  localparam opcode_t OP_JAL     = 7'b11_011_11;
  localparam opcode_t OP_REG_IMM = 7'b00_100_11;
  localparam opcode_t OP_REG_REG = 7'b01_100_11;
  localparam opcode_t OP_SYSTEM  = 7'b11_100_11;
  localparam opcode_t OP_AUIPC   = 7'b00_101_11;
  localparam opcode_t OP_LUI     = 7'b01_101_11;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // alu operations, shared by register and immediate forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 of sub and sra/srai
  localparam logic [6:0] ALT_FUNCT7 = 7'b010_0000;

  localparam insn_t NOP_INSN = 32'h0000_0000;

  // true for every kept instruction that has a destination register
  function automatic logic writes_rd(opcode_t op);
    return op inside {OP_LOAD, OP_LUI, OP_AUIPC, OP_REG_IMM, OP_REG_REG, OP_JAL, OP_JALR};
  endfunction

endpackage

`default_nettype wire
